//--- source/soc_config.svh
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// address map, regions decoded on addr[31:SOC_REGION_SHIFT]
`define SOC_RAM_BASE 32'h0000_0000
`define SOC_UART_BASE 32'h8000_0000
`define SOC_REGION_SHIFT 13

// on-chip ram, 32-bit words
`define SOC_RAM_WORDS 1024

// uart bit period in clocks
`define SOC_UART_CLKS_PER_BIT 8

`endif

//--- source/soc_bus_pkg.sv
package soc_bus_pkg;

  typedef logic [31:0] bus_addr_t; // byte address
  typedef logic [31:0] bus_data_t;
  typedef logic [3:0] bus_bytesel_t; // one bit per byte lane

  // master to slave, valid only in the access cycle
  typedef struct packed {
    logic access; // one-cycle strobe
    bus_addr_t addr;
    logic wr_en;
    bus_bytesel_t bytesel;
    bus_data_t wr_val;
  } bus_req_t;

  // slave to master, one cycle after the access
  typedef struct packed {
    logic ack; // single-cycle pulse
    logic error; // valid with ack
    bus_data_t data; // valid with ack on reads
  } bus_rsp_t;

endpackage

//--- source/uart_pkg.sv
package uart_pkg;

  typedef logic [7:0] uart_byte_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } uart_tx_state_t;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } uart_rx_state_t;

  // byte offsets inside the uart region
  localparam logic [3:0] UART_REG_DATA = 4'h0;
  localparam logic [3:0] UART_REG_STATUS = 4'h4;

endpackage

//--- source/soc_bus_decode.sv
`timescale 1ns/1ns
`include "soc_config.svh"

module soc_bus_decode (
  input logic clk,
  input logic i_rst,
  input soc_bus_pkg::bus_req_t i_req,
  input soc_bus_pkg::bus_rsp_t i_ram_rsp,
  input soc_bus_pkg::bus_rsp_t i_uart_rsp,
  output logic o_ram_cs,
  output logic o_uart_cs,
  output soc_bus_pkg::bus_rsp_t o_rsp
);

  localparam int REGION_SHIFT = `SOC_REGION_SHIFT;
  localparam soc_bus_pkg::bus_addr_t RAM_BASE = `SOC_RAM_BASE;
  localparam soc_bus_pkg::bus_addr_t UART_BASE = `SOC_UART_BASE;

  logic [31-REGION_SHIFT:0] region;
  logic unmapped_ack_q;

  assign region = i_req.addr[31:REGION_SHIFT];
  assign o_ram_cs = region == RAM_BASE[31:REGION_SHIFT];
  assign o_uart_cs = region == UART_BASE[31:REGION_SHIFT];

  // no slave owns the address, answer with an error so the master moves on
  always_ff @(posedge clk) begin
    if (i_rst) begin
      unmapped_ack_q <= 1'b0;
    end else begin
      unmapped_ack_q <= i_req.access && !o_ram_cs && !o_uart_cs;
    end
  end

  always_comb begin
    o_rsp.ack = i_ram_rsp.ack | i_uart_rsp.ack | unmapped_ack_q;
    o_rsp.error = i_ram_rsp.error | i_uart_rsp.error | unmapped_ack_q;
    if (i_ram_rsp.ack) begin
      o_rsp.data = i_ram_rsp.data;
    end else if (i_uart_rsp.ack) begin
      o_rsp.data = i_uart_rsp.data;
    end else begin
      o_rsp.data = '0; // unmapped reads return zero
    end
  end

  cs_onehot : assert property (@(posedge clk) !(o_ram_cs && o_uart_cs));

  // master waits for each ack, so merged acks never run together
  ack_single : assert property (@(posedge clk) disable iff (i_rst)
    o_rsp.ack |=> !o_rsp.ack);

endmodule

//--- source/soc_dp_ram.sv
`timescale 1ns/1ns
`include "soc_config.svh"

module soc_dp_ram (
  input logic clk,
  input logic i_rst,
  input soc_bus_pkg::bus_addr_t i_i_addr,
  output soc_bus_pkg::bus_data_t o_i_data,
  input soc_bus_pkg::bus_req_t i_req,
  input logic i_cs,
  output soc_bus_pkg::bus_rsp_t o_rsp
);

  localparam int IDX_W = $clog2(`SOC_RAM_WORDS);

  soc_bus_pkg::bus_data_t mem [`SOC_RAM_WORDS];
  soc_bus_pkg::bus_data_t rd_q;
  logic [IDX_W-1:0] i_idx;
  logic [IDX_W-1:0] d_idx;
  logic hit;
  logic ack_q;

  assign i_idx = i_i_addr[IDX_W+1:2]; // word index
  assign d_idx = i_req.addr[IDX_W+1:2];
  assign hit = i_req.access && i_cs;

  // both ports read the old word, writes land at the same edge
  always_ff @(posedge clk) begin
    o_i_data <= mem[i_idx];
    if (hit) begin
      rd_q <= mem[d_idx];
      for (int b = 0; b < 4; b++) begin
        if (i_req.wr_en && i_req.bytesel[b]) begin
          mem[d_idx][b*8 +: 8] <= i_req.wr_val[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= hit;
    end
  end

  assign o_rsp.ack = ack_q;
  assign o_rsp.error = 1'b0; // ram never faults
  assign o_rsp.data = rd_q;

  ack_after_access : assert property (@(posedge clk) disable iff (i_rst)
    hit |=> o_rsp.ack);

  ack_has_access : assert property (@(posedge clk) disable iff (i_rst)
    o_rsp.ack |-> $past(hit));

endmodule

//--- source/soc_uart.sv
`timescale 1ns/1ns
`include "soc_config.svh"

module soc_uart (
  input logic clk,
  input logic i_rst,
  input soc_bus_pkg::bus_req_t i_req,
  input logic i_cs,
  output soc_bus_pkg::bus_rsp_t o_rsp,
  input logic i_rx,
  output logic o_tx
);

  localparam int CPB = `SOC_UART_CLKS_PER_BIT;
  localparam int CNT_W = $clog2(CPB + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CPB - 1);
  localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(CPB / 2); // mid start bit

  uart_pkg::uart_tx_state_t tx_state;
  uart_pkg::uart_rx_state_t rx_state;
  uart_pkg::uart_byte_t tx_shift;
  uart_pkg::uart_byte_t rx_shift;
  uart_pkg::uart_byte_t rx_byte;
  logic [CNT_W-1:0] tx_cnt;
  logic [CNT_W-1:0] rx_cnt;
  logic [2:0] tx_bit;
  logic [2:0] rx_bit;
  logic tx_q;
  logic rx_meta;
  logic rx_s;
  logic rx_valid;
  logic tx_busy;
  logic hit;
  logic wr_data;
  logic rd_data;
  logic tx_start;
  logic ack_q;
  logic err_q;
  soc_bus_pkg::bus_data_t rd_q;

  assign hit = i_req.access && i_cs;
  assign tx_busy = tx_state != uart_pkg::TX_IDLE;
  assign wr_data = hit && i_req.wr_en && i_req.addr[3:0] == uart_pkg::UART_REG_DATA;
  assign rd_data = hit && !i_req.wr_en && i_req.addr[3:0] == uart_pkg::UART_REG_DATA;
  assign tx_start = wr_data && !tx_busy;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= hit;
      err_q <= wr_data && tx_busy; // byte dropped
    end
  end

  always_ff @(posedge clk) begin
    if (hit) begin
      case (i_req.addr[3:0])
        uart_pkg::UART_REG_DATA: rd_q <= {24'b0, rx_byte};
        uart_pkg::UART_REG_STATUS: rd_q <= {30'b0, rx_valid, tx_busy};
        default: rd_q <= '0;
      endcase
    end
  end

  assign o_rsp.ack = ack_q;
  assign o_rsp.error = err_q;
  assign o_rsp.data = rd_q;

  // tx line only changes on bit boundaries
  always_ff @(posedge clk) begin
    if (i_rst) begin
      tx_state <= uart_pkg::TX_IDLE;
      tx_cnt <= '0;
      tx_bit <= '0;
      tx_q <= 1'b1;
    end else begin
      tx_cnt <= tx_cnt + 1'b1;
      case (tx_state)
        uart_pkg::TX_IDLE: begin
          tx_cnt <= '0;
          if (tx_start) begin
            tx_shift <= i_req.wr_val[7:0];
            tx_q <= 1'b0; // start bit
            tx_state <= uart_pkg::TX_START;
          end
        end
        uart_pkg::TX_START: begin
          if (tx_cnt == CNT_LAST) begin
            tx_cnt <= '0;
            tx_bit <= '0;
            tx_q <= tx_shift[0];
            tx_shift <= tx_shift >> 1;
            tx_state <= uart_pkg::TX_DATA;
          end
        end
        uart_pkg::TX_DATA: begin
          if (tx_cnt == CNT_LAST) begin
            tx_cnt <= '0;
            tx_bit <= tx_bit + 1'b1;
            if (tx_bit == 3'd7) begin
              tx_q <= 1'b1; // stop bit
              tx_state <= uart_pkg::TX_STOP;
            end else begin
              tx_q <= tx_shift[0];
              tx_shift <= tx_shift >> 1;
            end
          end
        end
        uart_pkg::TX_STOP: begin
          if (tx_cnt == CNT_LAST) begin
            tx_cnt <= '0;
            tx_state <= uart_pkg::TX_IDLE;
          end
        end
      endcase
    end
  end

  assign o_tx = tx_q;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      rx_meta <= 1'b1;
      rx_s <= 1'b1;
      rx_state <= uart_pkg::RX_IDLE;
      rx_cnt <= '0;
      rx_bit <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_meta <= i_rx; // 2-flop sync
      rx_s <= rx_meta;
      rx_cnt <= rx_cnt + 1'b1;
      if (rd_data) begin
        rx_valid <= 1'b0;
      end
      case (rx_state)
        uart_pkg::RX_IDLE: begin
          rx_cnt <= '0;
          if (!rx_s) begin
            rx_state <= uart_pkg::RX_START;
          end
        end
        uart_pkg::RX_START: begin
          if (rx_cnt == CNT_HALF) begin
            rx_cnt <= '0;
            rx_bit <= '0;
            // glitch if line went back high
            rx_state <= rx_s ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
          end
        end
        uart_pkg::RX_DATA: begin
          if (rx_cnt == CNT_LAST) begin
            rx_cnt <= '0;
            rx_shift <= {rx_s, rx_shift[7:1]}; // lsb first
            rx_bit <= rx_bit + 1'b1;
            if (rx_bit == 3'd7) begin
              rx_state <= uart_pkg::RX_STOP;
            end
          end
        end
        uart_pkg::RX_STOP: begin
          if (rx_cnt == CNT_LAST) begin
            rx_state <= uart_pkg::RX_IDLE;
            if (rx_s) begin
              rx_byte <= rx_shift;
              rx_valid <= 1'b1; // wins over a same-cycle read
            end
          end
        end
      endcase
    end
  end

  tx_idle_high : assert property (@(posedge clk) disable iff (i_rst)
    (tx_state == uart_pkg::TX_IDLE) |-> o_tx);

endmodule

//--- source/soc_top.sv
`timescale 1ns/1ns

module soc_top (
  input logic clk,
  input logic i_rst,
  input soc_bus_pkg::bus_req_t i_d_req,
  output soc_bus_pkg::bus_rsp_t o_d_rsp,
  input soc_bus_pkg::bus_addr_t i_i_addr,
  output soc_bus_pkg::bus_data_t o_i_data,
  input logic i_uart_rx,
  output logic o_uart_tx
);

  logic ram_cs;
  logic uart_cs;
  soc_bus_pkg::bus_rsp_t ram_rsp;
  soc_bus_pkg::bus_rsp_t uart_rsp;

  soc_bus_decode decode0 (
    .clk(clk),
    .i_rst(i_rst),
    .i_req(i_d_req),
    .i_ram_rsp(ram_rsp),
    .i_uart_rsp(uart_rsp),
    .o_ram_cs(ram_cs),
    .o_uart_cs(uart_cs),
    .o_rsp(o_d_rsp)
  );

  soc_dp_ram ram0 (
    .clk(clk),
    .i_rst(i_rst),
    .i_i_addr(i_i_addr),
    .o_i_data(o_i_data),
    .i_req(i_d_req),
    .i_cs(ram_cs),
    .o_rsp(ram_rsp)
  );

  soc_uart uart0 (
    .clk(clk),
    .i_rst(i_rst),
    .i_req(i_d_req),
    .i_cs(uart_cs),
    .o_rsp(uart_rsp),
    .i_rx(i_uart_rx),
    .o_tx(o_uart_tx)
  );

endmodule

//--- tests/tb_soc.sv
`timescale 1ns/1ns
`include "soc_config.svh"

module tb_soc;

  localparam int CLK_PERIOD = 10;
  localparam int CPB = `SOC_UART_CLKS_PER_BIT;
  localparam int N_WORDS = 20; // each word gets a full write, a lane write and a read
  localparam int UART_FRAMES = 4;
  localparam int WATCHDOG_CYCLES = 2 * (9 * N_WORDS + UART_FRAMES * 10 * CPB) + 100;
  localparam int POLL_LIMIT = 10 * CPB;
  localparam soc_bus_pkg::bus_addr_t UART_DATA = `SOC_UART_BASE;
  localparam soc_bus_pkg::bus_addr_t UART_STATUS = `SOC_UART_BASE + 32'h4;

  logic clk = 1'b0;
  logic rst;
  soc_bus_pkg::bus_req_t d_req;
  soc_bus_pkg::bus_rsp_t d_rsp;
  soc_bus_pkg::bus_addr_t fetch_addr;
  soc_bus_pkg::bus_data_t fetch_data;
  wire uart_line; // tx looped back to rx
  logic exp_err;
  soc_bus_pkg::bus_data_t exp_mask; // zero skips the data compare
  soc_bus_pkg::bus_data_t exp_data;
  logic fetch_chk;
  logic fetch_chk_q;
  soc_bus_pkg::bus_data_t exp_fetch;
  soc_bus_pkg::bus_data_t exp_fetch_q;
  soc_bus_pkg::bus_data_t shadow [`SOC_RAM_WORDS];
  logic [7:0] rx_expect [$];
  logic [7:0] line_byte;
  logic [7:0] line_exp;
  logic line_stop;
  logic line_done;

  soc_top dut0 (
    .clk(clk),
    .i_rst(rst),
    .i_d_req(d_req),
    .o_d_rsp(d_rsp),
    .i_i_addr(fetch_addr),
    .o_i_data(fetch_data),
    .i_uart_rx(uart_line),
    .o_uart_tx(uart_line)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    fetch_chk_q <= fetch_chk; // fetch data lands one edge later
    exp_fetch_q <= exp_fetch;
  end

  function automatic void abort_run(string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endfunction

  function automatic soc_bus_pkg::bus_data_t merge_lanes(soc_bus_pkg::bus_data_t old,
      soc_bus_pkg::bus_data_t val, soc_bus_pkg::bus_bytesel_t sel);
    soc_bus_pkg::bus_data_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) res[b*8 +: 8] = val[b*8 +: 8];
    end
    return res;
  endfunction

  // independent 8N1 decode of the tx line, sampled mid-bit
  always begin
    @(negedge uart_line);
    repeat (CPB / 2) @(negedge clk);
    for (int b = 0; b < 8; b++) begin
      repeat (CPB) @(negedge clk);
      line_byte[b] = uart_line;
    end
    repeat (CPB) @(negedge clk);
    line_stop = uart_line;
    if (rx_expect.size() == 0) begin
      abort_run("uart tx line sent a frame that was never written");
    end
    line_exp = rx_expect[0];
    line_done = 1'b1;
    @(negedge clk);
    line_done = 1'b0;
  end

  ack_follows_access : assert property (@(posedge clk) disable iff (rst)
    d_req.access |=> d_rsp.ack)
    else abort_run($sformatf("FAIL %0t o_d_rsp.ack expected 1 got 0", $time));

  ack_needs_access : assert property (@(posedge clk) disable iff (rst)
    d_rsp.ack |-> $past(d_req.access))
    else abort_run($sformatf("FAIL %0t o_d_rsp.ack expected 0 got 1", $time));

  error_level : assert property (@(posedge clk) disable iff (rst)
    d_rsp.ack |-> d_rsp.error == exp_err)
    else abort_run($sformatf("FAIL %0t o_d_rsp.error expected %0b got %0b",
      $time, exp_err, $sampled(d_rsp.error)));

  read_value : assert property (@(posedge clk) disable iff (rst)
    d_rsp.ack |-> (d_rsp.data & exp_mask) == exp_data)
    else abort_run($sformatf("FAIL %0t o_d_rsp.data expected %h got %h",
      $time, exp_data, $sampled(d_rsp.data) & exp_mask));

  fetch_value : assert property (@(posedge clk) disable iff (rst)
    fetch_chk_q |-> fetch_data == exp_fetch_q)
    else abort_run($sformatf("FAIL %0t o_i_data expected %h got %h",
      $time, $sampled(exp_fetch_q), $sampled(fetch_data)));

  tx_frame_byte : assert property (@(posedge clk) disable iff (rst)
    line_done |-> line_byte == line_exp)
    else abort_run($sformatf("FAIL %0t o_uart_tx byte expected %h got %h",
      $time, $sampled(line_exp), $sampled(line_byte)));

  tx_stop_bit : assert property (@(posedge clk) disable iff (rst)
    line_done |-> line_stop)
    else abort_run($sformatf("FAIL %0t o_uart_tx stop bit expected 1 got 0", $time));

  // expected response stays set until the ack is checked
  task automatic bus_access(input soc_bus_pkg::bus_addr_t addr, input logic wr,
      input soc_bus_pkg::bus_bytesel_t sel, input soc_bus_pkg::bus_data_t val,
      input logic err, input soc_bus_pkg::bus_data_t mask,
      input soc_bus_pkg::bus_data_t data, output soc_bus_pkg::bus_data_t rdata);
    int waited;
    @(negedge clk);
    d_req = '{access: 1'b1, addr: addr, wr_en: wr, bytesel: sel, wr_val: val};
    exp_err = err;
    exp_mask = mask;
    exp_data = data;
    waited = 0;
    @(negedge clk);
    d_req = '0;
    while (!d_rsp.ack) begin
      if (waited == 4) abort_run("no ack on the data bus");
      @(negedge clk);
      waited++;
    end
    rdata = d_rsp.data;
  endtask

  task automatic wait_rx_valid();
    soc_bus_pkg::bus_data_t st;
    int polls;
    st = '0;
    polls = 0;
    while (!st[1]) begin
      if (polls == POLL_LIMIT) abort_run("uart receiver never set rx_valid");
      bus_access(UART_STATUS, 1'b0, 4'h0, '0, 1'b0, '0, '0, st);
      polls++;
    end
  endtask

  task automatic read_rx_byte();
    soc_bus_pkg::bus_data_t rdata;
    bus_access(UART_DATA, 1'b0, 4'h0, '0, 1'b0, 32'hff, {24'b0, rx_expect.pop_front()},
      rdata);
    bus_access(UART_STATUS, 1'b0, 4'h0, '0, 1'b0, 32'h2, 32'h0, rdata); // rx_valid cleared
  endtask

  initial begin
    soc_bus_pkg::bus_data_t rdata;
    soc_bus_pkg::bus_data_t val;
    soc_bus_pkg::bus_bytesel_t sel;
    int unsigned idx [N_WORDS];
    int unsigned seed;
    logic [7:0] tx_byte;
    seed = 32'h2e2c_4145;
    void'($urandom(seed));
    rst = 1'b1;
    d_req = '0;
    fetch_addr = '0;
    exp_err = 1'b0;
    exp_mask = '0;
    exp_data = '0;
    fetch_chk = 1'b0;
    exp_fetch = '0;
    line_done = 1'b0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    for (int n = 0; n < N_WORDS; n++) begin
      idx[n] = $urandom % `SOC_RAM_WORDS;
      val = $urandom;
      shadow[idx[n]] = val; // whole word so no lane stays unknown
      bus_access(`SOC_RAM_BASE + idx[n] * 4, 1'b1, 4'hf, val, 1'b0, '0, '0, rdata);
    end
    for (int n = 0; n < N_WORDS; n++) begin
      val = $urandom;
      sel = 4'($urandom);
      shadow[idx[n]] = merge_lanes(shadow[idx[n]], val, sel);
      bus_access(`SOC_RAM_BASE + idx[n] * 4, 1'b1, sel, val, 1'b0, '0, '0, rdata);
    end
    for (int n = 0; n < N_WORDS; n++) begin
      fetch_addr = `SOC_RAM_BASE + idx[n] * 4;
      exp_fetch = shadow[idx[n]];
      fetch_chk = 1'b1;
      bus_access(fetch_addr, 1'b0, 4'h0, '0, 1'b0, '1, shadow[idx[n]], rdata);
    end
    fetch_chk = 1'b0;
    bus_access(32'h4000_0010, 1'b1, 4'hf, $urandom, 1'b1, '1, '0, rdata);
    bus_access(32'h4000_0010, 1'b0, 4'h0, '0, 1'b1, '1, '0, rdata);
    bus_access(32'h0000_2000, 1'b0, 4'h0, '0, 1'b1, '1, '0, rdata); // just past the ram
    repeat (2) begin
      tx_byte = 8'($urandom);
      rx_expect.push_back(tx_byte);
      bus_access(UART_DATA, 1'b1, 4'h1, {24'b0, tx_byte}, 1'b0, '0, '0, rdata);
      wait_rx_valid();
      bus_access(UART_STATUS, 1'b0, 4'h0, '0, 1'b0, 32'h2, 32'h2, rdata);
      read_rx_byte();
    end
    tx_byte = 8'($urandom);
    rx_expect.push_back(tx_byte);
    bus_access(UART_DATA, 1'b1, 4'h1, {24'b0, tx_byte}, 1'b0, '0, '0, rdata);
    bus_access(UART_DATA, 1'b1, 4'h1, {24'b0, ~tx_byte}, 1'b1, '0, '0, rdata); // busy
    wait_rx_valid();
    read_rx_byte();
    repeat (12 * CPB) @(negedge clk); // a dropped byte would arrive by now
    bus_access(UART_STATUS, 1'b0, 4'h0, '0, 1'b0, 32'h2, 32'h0, rdata);
    $display("Verification passed");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    abort_run("watchdog expired before the tests finished");
  end

endmodule

//--- files.f
+incdir+source
source/soc_bus_pkg.sv
source/uart_pkg.sv
source/soc_bus_decode.sv
source/soc_dp_ram.sv
source/soc_uart.sv
source/soc_top.sv
tests/tb_soc.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --timing --assert
TOP ?= tb_soc
FILELIST ?= files.f
BUILD_DIR ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
